// File: source/uart_rx_settings.svh
/*
 * UART receive analyser constants
 * raw word bit positions, frame gap threshold and frame queue depth
 */
`ifndef UART_RX_SETTINGS_SVH
`define UART_RX_SETTINGS_SVH

// data field inside the 12-bit raw word from the shift register
`define UART_RX_DATA_MSB 10
`define UART_RX_DATA_LSB 3
`define UART_RX_PARITY_BIT 2
`define UART_RX_STOP_BIT 1

// eleven bit times of one byte plus seventeen idle ticks close a frame
`define UART_RX_GAP_TICKS 28
`define UART_RX_GAP_MAX 255

// legal range of the time stamp fields
`define UART_RX_MS_MAX 999
`define UART_RX_FRAC_MAX 9

`define UART_RX_QUEUE_DEPTH 4
`endif

// File: source/uart_rx_pkg.sv
/*
 * UART receive analyser types
 * vector typedefs and the structs passed between pipeline stages
 */
package uart_rx_pkg;

    // plain vectors with a meaning
    typedef logic [11:0] raw_word_t;
    typedef logic [7:0]  data_byte_t;
    typedef logic [11:0] stamp_ms_t;
    typedef logic [3:0]  stamp_frac_t;
    typedef logic [11:0] byte_count_t;
    typedef logic [7:0]  gap_count_t;
    typedef logic [7:0]  err_count_t;

    // tenths of a millisecond sit on top
    typedef struct packed {
        stamp_frac_t frac;
        stamp_ms_t   ms;
    } time_stamp_t;

    // stage 1 output
    typedef struct packed {
        logic        valid;
        raw_word_t   raw;
        time_stamp_t stamp;
    } captured_t;

    // stage 2 output
    typedef struct packed {
        logic        valid;
        data_byte_t  data;
        logic        parity_ok;
        logic        stop_ok;
        time_stamp_t stamp;
    } checked_t;

    // frame summary, frac ends up in bits 27:24
    typedef struct packed {
        time_stamp_t stamp;
        byte_count_t count;
    } frame_info_t;

    typedef struct packed {
        logic       parity_err;
        logic       frame_err;
        err_count_t parity_err_cnt;
    } rx_status_t;

endpackage

// File: source/byte_capture.sv
/*
 * byte capture stage
 * latches the raw receive word and its time stamp on each sync pulse
 */
`timescale 1ns/1ns
`include "uart_rx_settings.svh"

module byte_capture (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     byte_sync_i,
    input  uart_rx_pkg::raw_word_t   raw_i,
    input  uart_rx_pkg::time_stamp_t stamp_i,
    output uart_rx_pkg::captured_t   cap_o
);
    import uart_rx_pkg::*;

    logic        valid_q;
    raw_word_t   raw_q;
    time_stamp_t stamp_q;

    //----------------------------------------------------------------------
    // valid follows sync, one bit per cycle so back-to-back bytes work
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= byte_sync_i;
        end
    end

    // payload only moves on a sync
    always_ff @(posedge clk) begin
        if (byte_sync_i) begin
            raw_q   <= raw_i;
            stamp_q <= stamp_i;
        end
    end

    assign cap_o = '{valid: valid_q, raw: raw_q, stamp: stamp_q};

    //----------------------------------------------------------------------
    // time stamp source must hand over a legal ms / tenths pair
    stamp_range_a : assert property (@(posedge clk) disable iff (!rst)
        byte_sync_i |-> (stamp_i.ms <= stamp_ms_t'(`UART_RX_MS_MAX))
                        && (stamp_i.frac <= stamp_frac_t'(`UART_RX_FRAC_MAX)));

endmodule

// File: source/byte_check.sv
/*
 * byte check stage
 * orders the data bits, computes even parity and tests the stop bit
 */
`timescale 1ns/1ns
`include "uart_rx_settings.svh"

module byte_check (
    input  logic                   clk,
    input  logic                   rst,
    input  uart_rx_pkg::captured_t cap_i,
    input  logic                   parity_en_i,
    input  logic                   msb_first_i,
    output uart_rx_pkg::checked_t  chk_o
);
    import uart_rx_pkg::*;

    data_byte_t  field_w;
    data_byte_t  ordered_w;
    logic        parity_ok_w;
    logic        stop_ok_w;

    logic        valid_q;
    data_byte_t  data_q;
    logic        parity_ok_q;
    logic        stop_ok_q;
    time_stamp_t stamp_q;

    //----------------------------------------------------------------------
    // data field as it sits on the wire
    assign field_w = cap_i.raw[`UART_RX_DATA_MSB:`UART_RX_DATA_LSB];

    // msb first keeps the field, lsb first mirrors it
    always_comb begin
        for (int i = 0; i < $bits(data_byte_t); i++) begin
            ordered_w[i] = msb_first_i ? field_w[i] : field_w[$bits(data_byte_t) - 1 - i];
        end
    end

    // even parity over data and parity bit, forced good when disabled
    assign parity_ok_w = !parity_en_i || !(^{field_w, cap_i.raw[`UART_RX_PARITY_BIT]});
    assign stop_ok_w   = cap_i.raw[`UART_RX_STOP_BIT];

    //----------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= cap_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        data_q      <= ordered_w;
        parity_ok_q <= parity_ok_w;
        stop_ok_q   <= stop_ok_w;
        stamp_q     <= cap_i.stamp;
    end

    assign chk_o = '{valid: valid_q, data: data_q, parity_ok: parity_ok_q,
                     stop_ok: stop_ok_q, stamp: stamp_q};

endmodule

// File: source/byte_commit.sv
/*
 * byte commit stage
 * strobes good bytes out and keeps the parity / framing error status
 */
`timescale 1ns/1ns

module byte_commit (
    input  logic                     clk,
    input  logic                     rst,
    input  uart_rx_pkg::checked_t    chk_i,
    output logic                     byte_valid_o,
    output uart_rx_pkg::data_byte_t  byte_o,
    output logic                     good_byte_o,
    output uart_rx_pkg::time_stamp_t good_stamp_o,
    output uart_rx_pkg::rx_status_t  status_o
);
    import uart_rx_pkg::*;

    logic        good_w;
    logic        good_q;
    data_byte_t  byte_q;
    time_stamp_t stamp_q;
    rx_status_t  status_q;

    assign good_w = chk_i.valid && chk_i.parity_ok && chk_i.stop_ok;

    //----------------------------------------------------------------------
    // strobe and status flags follow every checked byte good or bad
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            good_q   <= 1'b0;
            status_q <= '0;
        end else begin
            good_q <= good_w;
            if (chk_i.valid) begin
                status_q.parity_err <= !chk_i.parity_ok;
                status_q.frame_err  <= !chk_i.stop_ok;
                // wraps at 255
                status_q.parity_err_cnt <= status_q.parity_err_cnt + err_count_t'(!chk_i.parity_ok);
            end
        end
    end

    always_ff @(posedge clk) begin
        byte_q  <= chk_i.data;
        stamp_q <= chk_i.stamp;
    end

    assign byte_valid_o = good_q;
    assign good_byte_o  = good_q;
    assign byte_o       = byte_q;
    assign good_stamp_o = stamp_q;
    assign status_o     = status_q;

    // a strobed byte leaves both error flags clear
    strobe_clean_a : assert property (@(posedge clk) disable iff (!rst)
        byte_valid_o |-> !status_o.parity_err && !status_o.frame_err);

endmodule

// File: source/frame_gap_detect.sv
/*
 * frame gap detector
 * counts baud ticks since the last byte sync and closes the open frame
 */
`timescale 1ns/1ns
`include "uart_rx_settings.svh"

module frame_gap_detect (
    input  logic clk,
    input  logic rst,
    input  logic byte_sync_i,
    input  logic baud_tick_i,
    output logic frame_close_o
);
    import uart_rx_pkg::*;

    gap_count_t gap_q;
    logic       close_q;
    logic       reach_w;

    // this tick takes the counter onto the threshold
    assign reach_w = baud_tick_i && !byte_sync_i
                     && (gap_q == gap_count_t'(`UART_RX_GAP_TICKS - 1));

    //----------------------------------------------------------------------
    // starts saturated so nothing closes before the first byte
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            gap_q <= gap_count_t'(`UART_RX_GAP_MAX);
        end else if (byte_sync_i) begin
            gap_q <= '0;
        end else if (baud_tick_i && (gap_q != gap_count_t'(`UART_RX_GAP_MAX))) begin
            gap_q <= gap_q + 1'b1;
        end
    end

    // the threshold is crossed once per quiet period, so one pulse only
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            close_q <= 1'b0;
        end else begin
            close_q <= reach_w;
        end
    end

    assign frame_close_o = close_q;

endmodule

// File: source/frame_info_queue.sv
/*
 * frame information queue
 * counts good bytes of the open frame and keeps the last frame summaries,
 * read out through a valid/ready pop
 */
`timescale 1ns/1ns

module frame_info_queue #(
    parameter int DEPTH = 4
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       good_byte_i,
    input  uart_rx_pkg::time_stamp_t   good_stamp_i,
    input  logic                       frame_close_i,
    input  logic                       frame_ready_i,
    output logic                       frame_valid_o,
    output uart_rx_pkg::frame_info_t   frame_info_o
);
    import uart_rx_pkg::*;

    localparam int CW = $clog2(DEPTH + 1);
    localparam int IW = $clog2(DEPTH);

    // open frame
    byte_count_t open_cnt_q;
    time_stamp_t first_stamp_q;

    // queue, head at index 0
    frame_info_t     entries_q [DEPTH];
    logic [CW-1:0]   used_q;

    logic            push_w;
    logic            pop_w;
    logic            full_w;
    logic            shift_w;
    logic [IW-1:0]   wr_idx_w;

    //----------------------------------------------------------------------
    // open frame bookkeeping
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            open_cnt_q <= '0;
        end else if (frame_close_i) begin
            // a byte on the closing edge already belongs to the next frame
            open_cnt_q <= byte_count_t'(good_byte_i);
        end else if (good_byte_i) begin
            open_cnt_q <= open_cnt_q + 1'b1;
        end
    end

    // stamp of the first good byte only
    always_ff @(posedge clk) begin
        if (good_byte_i && (frame_close_i || (open_cnt_q == '0))) begin
            first_stamp_q <= good_stamp_i;
        end
    end

    //----------------------------------------------------------------------
    // queue control
    assign push_w   = frame_close_i && (open_cnt_q != '0);
    assign pop_w    = frame_valid_o && frame_ready_i;
    assign full_w   = (used_q == CW'(DEPTH));
    // full push drops the head, same as a pop
    assign shift_w  = pop_w || (push_w && full_w);
    assign wr_idx_w = IW'(shift_w ? used_q - 1'b1 : used_q);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            used_q <= '0;
        end else if (push_w && !shift_w) begin
            used_q <= used_q + 1'b1;
        end else if (pop_w && !push_w) begin
            used_q <= used_q - 1'b1;
        end
    end

    // storage, later write wins over the shift
    always_ff @(posedge clk) begin
        if (shift_w) begin
            for (int i = 0; i < DEPTH - 1; i++) begin
                entries_q[i] <= entries_q[i + 1];
            end
        end
        if (push_w) begin
            entries_q[wr_idx_w] <= '{stamp: first_stamp_q, count: open_cnt_q};
        end
    end

    assign frame_valid_o = (used_q != '0);
    assign frame_info_o  = entries_q[0];

    used_bound_a : assert property (@(posedge clk) disable iff (!rst)
        used_q <= CW'(DEPTH));

endmodule

// File: source/uart_rx_analyse.sv
/*
 * UART receive byte analyser, top level
 * capture / check / commit pipeline with frame gap detection and
 * a queue of frame summaries
 */
`timescale 1ns/1ns
`include "uart_rx_settings.svh"

module uart_rx_analyse (
    input  logic                     clk,
    input  logic                     rst,
    // shift register side
    input  logic                     byte_sync_i,
    input  uart_rx_pkg::raw_word_t   raw_i,
    input  uart_rx_pkg::time_stamp_t stamp_i,
    input  logic                     baud_tick_i,
    // control
    input  logic                     parity_en_i,
    input  logic                     msb_first_i,
    // byte stream, one-cycle strobe and no back-pressure
    output logic                     byte_valid_o,
    output uart_rx_pkg::data_byte_t  byte_o,
    output uart_rx_pkg::rx_status_t  status_o,
    // frame summaries
    input  logic                     frame_ready_i,
    output logic                     frame_valid_o,
    output uart_rx_pkg::frame_info_t frame_info_o
);
    import uart_rx_pkg::*;

    captured_t   cap_w;
    checked_t    chk_w;
    logic        good_byte_w;
    time_stamp_t good_stamp_w;
    logic        frame_close_w;

    //----------------------------------------------------------------------
    // byte pipeline
    byte_capture u_capture (
        .clk         (clk),
        .rst         (rst),
        .byte_sync_i (byte_sync_i),
        .raw_i       (raw_i),
        .stamp_i     (stamp_i),
        .cap_o       (cap_w)
    );

    byte_check u_check (
        .clk         (clk),
        .rst         (rst),
        .cap_i       (cap_w),
        .parity_en_i (parity_en_i),
        .msb_first_i (msb_first_i),
        .chk_o       (chk_w)
    );

    byte_commit u_commit (
        .clk          (clk),
        .rst          (rst),
        .chk_i        (chk_w),
        .byte_valid_o (byte_valid_o),
        .byte_o       (byte_o),
        .good_byte_o  (good_byte_w),
        .good_stamp_o (good_stamp_w),
        .status_o     (status_o)
    );

    //----------------------------------------------------------------------
    // frame tracking
    frame_gap_detect u_gap (
        .clk           (clk),
        .rst           (rst),
        .byte_sync_i   (byte_sync_i),
        .baud_tick_i   (baud_tick_i),
        .frame_close_o (frame_close_w)
    );

    frame_info_queue #(
        .DEPTH (`UART_RX_QUEUE_DEPTH)
    ) u_queue (
        .clk           (clk),
        .rst           (rst),
        .good_byte_i   (good_byte_w),
        .good_stamp_i  (good_stamp_w),
        .frame_close_i (frame_close_w),
        .frame_ready_i (frame_ready_i),
        .frame_valid_o (frame_valid_o),
        .frame_info_o  (frame_info_o)
    );

endmodule

// File: dv/rx_checker.sv
/*
 * checker for the UART receive byte analyser
 * compares strobed bytes, status and popped frame summaries in order
 */
`timescale 1ns/1ns

module rx_checker (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     byte_sync_i,
    input  logic                     byte_valid_i,
    input  uart_rx_pkg::data_byte_t  byte_i,
    input  uart_rx_pkg::rx_status_t  status_i,
    input  logic                     frame_valid_i,
    input  logic                     frame_ready_i,
    input  uart_rx_pkg::frame_info_t frame_info_i,
    output int                       tests_o,
    output int                       errors_o,
    output logic                     done_o
);
    import uart_rx_pkg::*;

    // expectations in record order
    data_byte_t  exp_byte [$];
    logic        exp_drop [$];
    rx_status_t  exp_stat [$];
    frame_info_t exp_frame [$];

    // cycle on which each synced byte is due at the outputs
    int          due_cycle [$];
    int          cycle;
    int          byte_idx;
    int          frame_idx;
    int          tests;
    int          failed;

    initial begin
        int          fd;
        int          n;
        int          gap;
        int          pen;
        int          msbf;
        string       line;
        string       kind;
        string       tok;
        logic [31:0] raw;
        logic [31:0] stamp;
        logic [31:0] val;
        logic [31:0] pe;
        logic [31:0] fe;
        logic [31:0] cnt;
        rx_status_t  st;
        done_o = 1'b0;
        fd = $fopen("dv/analyse_input.txt", "r");
        if (fd == 0) begin
            $display("checker could not open dv/analyse_input.txt");
            failed++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%s %d %h %h %d %d %s %h %h %h",
                                kind, gap, raw, stamp, pen, msbf, tok, pe, fe, cnt);
                    if (kind == "B" && n == 10) begin
                        val = '0;
                        if (tok != "DROP") begin
                            n = $sscanf(tok, "%h", val);
                        end
                        st.parity_err     = pe[0];
                        st.frame_err      = fe[0];
                        st.parity_err_cnt = cnt[7:0];
                        exp_byte.push_back(val[7:0]);
                        exp_drop.push_back(tok == "DROP");
                        exp_stat.push_back(st);
                    end else if (kind == "F") begin
                        n = $sscanf(line, "%s %h", kind, val);
                        exp_frame.push_back(val[27:0]);
                    end
                end
            end
            $fclose(fd);
        end
    end

    //----------------------------------------------------------------------
    task automatic close_test(input string label, input logic ok);
        tests++;
        if (ok) begin
            $display("%s ok", label);
        end else begin
            failed++;
            $display("%s FAILED", label);
        end
    endtask

    // strobe, data and status of one byte record
    task automatic check_byte();
        logic ok;
        ok = 1'b1;
        if (byte_idx >= exp_byte.size()) begin
            $display("byte sync %0d has no record in the data file", byte_idx);
            ok = 1'b0;
        end else begin
            if (exp_drop[byte_idx]) begin
                if (byte_valid_i) begin
                    $display("byte %0d should be dropped but came out as %h", byte_idx, byte_i);
                    ok = 1'b0;
                end
            end else if (!byte_valid_i) begin
                $display("byte %0d missing, no strobe 3 cycles after its sync", byte_idx);
                ok = 1'b0;
            end else if (byte_i !== exp_byte[byte_idx]) begin
                $display("ERR byte %0d byte_o exp %h got %h", byte_idx, exp_byte[byte_idx], byte_i);
                ok = 1'b0;
            end
            if (status_i !== exp_stat[byte_idx]) begin
                $display("ERR byte %0d status_o exp %h got %h", byte_idx, exp_stat[byte_idx],
                         status_i);
                ok = 1'b0;
            end
        end
        close_test($sformatf("byte test %0d", byte_idx), ok);
        byte_idx++;
    endtask

    task automatic check_frame();
        logic ok;
        ok = 1'b1;
        if (frame_idx >= exp_frame.size()) begin
            $display("extra frame popped, %h beyond the expected list", frame_info_i);
            ok = 1'b0;
        end else if (frame_info_i !== exp_frame[frame_idx]) begin
            $display("ERR frame %0d frame_info_o exp %h got %h", frame_idx,
                     exp_frame[frame_idx], frame_info_i);
            ok = 1'b0;
        end
        close_test($sformatf("frame test %0d", frame_idx), ok);
        frame_idx++;
    endtask

    //----------------------------------------------------------------------
    // sampled on the same edge the DUT uses
    always @(posedge clk) begin
        if (rst) begin
            cycle++;
            if (due_cycle.size() > 0 && due_cycle[0] == cycle) begin
                void'(due_cycle.pop_front());
                check_byte();
            end else if (byte_valid_i) begin
                $display("byte strobe %h with no sync 3 cycles before it", byte_i);
                close_test("unexpected byte", 1'b0);
            end
            if (byte_sync_i) begin
                due_cycle.push_back(cycle + 3);
            end
            if (frame_valid_i && frame_ready_i) begin
                check_frame();
            end
        end
        tests_o  <= tests;
        errors_o <= failed;
        done_o   <= (byte_idx == exp_byte.size()) && (frame_idx == exp_frame.size());
    end

endmodule

// File: dv/tb_uart_rx_analyse.sv
/*
 * testbench for the UART receive byte analyser
 * file-driven byte stimulus, baud ticks and randomly paced frame pops
 */
`timescale 1ns/1ns

module tb_uart_rx_analyse;
    import uart_rx_pkg::*;

    // quiet ticks after the last byte so its frame closes
    localparam int TAIL_TICKS = 40;

    logic        clk;
    logic        rst;
    logic        byte_sync_i;
    raw_word_t   raw_i;
    time_stamp_t stamp_i;
    logic        baud_tick_i;
    logic        parity_en_i;
    logic        msb_first_i;
    logic        frame_ready_i;
    logic        byte_valid_o;
    data_byte_t  byte_o;
    rx_status_t  status_o;
    logic        frame_valid_o;
    frame_info_t frame_info_o;

    // byte records from the data file
    int          rec_gap [$];
    raw_word_t   rec_raw [$];
    time_stamp_t rec_stamp [$];
    logic        rec_pen [$];
    logic        rec_msbf [$];

    // per-byte settings waiting for the check stage
    logic        pen_next;
    logic        msbf_next;

    int          cycles;
    int          cycle_limit;
    logic [1:0]  tick_div;
    logic [16:0] lfsr;
    int          tests_w;
    int          fails_w;
    logic        done_w;

    uart_rx_analyse UUT (
        .clk           (clk),
        .rst           (rst),
        .byte_sync_i   (byte_sync_i),
        .raw_i         (raw_i),
        .stamp_i       (stamp_i),
        .baud_tick_i   (baud_tick_i),
        .parity_en_i   (parity_en_i),
        .msb_first_i   (msb_first_i),
        .byte_valid_o  (byte_valid_o),
        .byte_o        (byte_o),
        .status_o      (status_o),
        .frame_ready_i (frame_ready_i),
        .frame_valid_o (frame_valid_o),
        .frame_info_o  (frame_info_o)
    );

    rx_checker u_checker (
        .clk           (clk),
        .rst           (rst),
        .byte_sync_i   (byte_sync_i),
        .byte_valid_i  (byte_valid_o),
        .byte_i        (byte_o),
        .status_i      (status_o),
        .frame_valid_i (frame_valid_o),
        .frame_ready_i (frame_ready_i),
        .frame_info_i  (frame_info_o),
        .tests_o       (tests_w),
        .errors_o      (fails_w),
        .done_o        (done_w)
    );

    //----------------------------------------------------------------------
    // 17-bit Fibonacci LFSR with taps 17 and 14
    function automatic logic [16:0] lfsr_step(input logic [16:0] state);
        logic fb;
        fb = state[16] ^ state[13];
        return {state[15:0], fb};
    endfunction

    task automatic load_records();
        int          fd;
        int          n;
        int          recs;
        int          gap_sum;
        int          gap;
        int          pen;
        int          msbf;
        string       line;
        string       kind;
        logic [31:0] raw;
        logic [31:0] stamp;
        recs = 0;
        gap_sum = 0;
        fd = $fopen("dv/analyse_input.txt", "r");
        if (fd == 0) begin
            $display("stimulus file dv/analyse_input.txt could not be opened");
        end else begin
            while ($fgets(line, fd) != 0) begin
                // comment and blank lines carry no record
                if (line.len() > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%s %d %h %h %d %d", kind, gap, raw, stamp, pen, msbf);
                    recs++;
                    if (kind == "B" && n == 6) begin
                        rec_gap.push_back(gap);
                        rec_raw.push_back(raw[11:0]);
                        rec_stamp.push_back(stamp[15:0]);
                        rec_pen.push_back(pen[0]);
                        rec_msbf.push_back(msbf[0]);
                        gap_sum += gap;
                    end
                end
            end
            $fclose(fd);
        end
        // reset and tail on top of gaps times four plus 64 per record
        cycle_limit = 16 + (gap_sum + TAIL_TICKS) * 4 + 64 * recs;
    endtask

    // idle for the record's gap then one sync cycle with its word
    task automatic drive_byte(input int idx);
        repeat (rec_gap[idx] * 4) begin
            @(posedge clk);
            byte_sync_i <= 1'b0;
        end
        @(posedge clk);
        byte_sync_i <= 1'b1;
        raw_i       <= rec_raw[idx];
        stamp_i     <= rec_stamp[idx];
        pen_next    <= rec_pen[idx];
        msbf_next   <= rec_msbf[idx];
    endtask

    //----------------------------------------------------------------------
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // one baud tick every 4 clocks
    always @(posedge clk) begin
        tick_div    <= tick_div + 2'd1;
        baud_tick_i <= (tick_div == 2'd3);
    end

    // parity enable and bit order are used by the check stage one cycle after the sync
    always @(posedge clk) begin
        parity_en_i <= pen_next;
        msb_first_i <= msbf_next;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("timeout, run still going after %0d cycles", cycle_limit);
            $display("sim failed");
            $finish;
        end
    end

    initial begin
        rst           = 1'b0;
        byte_sync_i   = 1'b0;
        raw_i         = '0;
        stamp_i       = '0;
        baud_tick_i   = 1'b0;
        parity_en_i   = 1'b0;
        msb_first_i   = 1'b1;
        pen_next      = 1'b0;
        msbf_next     = 1'b1;
        frame_ready_i = 1'b0;
        tick_div      = 2'd0;
        lfsr          = 17'd85361;
        load_records();
        repeat (16) @(posedge clk);
        rst <= 1'b1;
        for (int i = 0; i < rec_gap.size(); i++) begin
            drive_byte(i);
        end
        @(posedge clk);
        byte_sync_i <= 1'b0;
        repeat (TAIL_TICKS * 4) @(posedge clk);
        // random pop pacing with one LFSR step per ready bit
        while (!done_w) begin
            @(posedge clk);
            lfsr = lfsr_step(lfsr);
            frame_ready_i <= lfsr[0];
        end
        // a leftover entry would now show up as an extra pop
        @(posedge clk);
        frame_ready_i <= 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        $display("tests run %0d, failed %0d", tests_w, fails_w);
        if (fails_w == 0 && tests_w > 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: dv/analyse_input.txt
# B gap_ticks raw stamp parity_en msb_first expected_byte|DROP parity_err frame_err err_count
# F frame_info, {frac, ms, good byte count} in hex, listed in pop order
B 4 52a 1064 1 1 a5 0 0 00
B 2 0f2 1065 1 0 78 0 0 00
B 40 03a 2200 1 1 DROP 1 0 01
B 2 03a 2201 0 1 07 0 0 01
B 2 2a8 2202 1 1 DROP 0 1 01
B 2 40a 2203 1 1 81 0 0 01
B 40 61a 3300 1 1 c3 0 0 01
B 0 4b2 3301 1 0 69 0 0 01
B 0 00e 3302 1 1 01 0 0 01
B 40 780 4050 1 1 DROP 0 1 01
B 2 012 4051 1 1 DROP 1 0 02
B 40 2d2 5123 1 1 5a 0 0 02
B 40 07a 63e7 1 0 f0 0 0 02
B 3 7fa 6010 0 1 ff 0 0 02
B 40 406 7001 1 0 01 0 0 02
F 3300003
F 5123001
F 63e7002
F 7001001

// File: verilog.f
+incdir+source
source/uart_rx_pkg.sv
source/byte_capture.sv
source/byte_check.sv
source/byte_commit.sv
source/frame_gap_detect.sv
source/frame_info_queue.sv
source/uart_rx_analyse.sv
dv/rx_checker.sv
dv/tb_uart_rx_analyse.sv

// File: run_sim.sh
#!/bin/sh
# build and run the UART receive analyser testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f verilog.f \
    --top-module tb_uart_rx_analyse -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log
if grep -q "^sim passed$" sim.log; then
    exit 0
else
    exit 1
fi
